// File: source/gmii_tx_pkg.sv
package gmii_tx_pkg;

    ////////////////////
    // frame constants
    ////////////////////

    localparam int unsigned LEN_W         = 11;         // length field in the descriptor
    localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0]  SFD_BYTE      = 8'hD5;
    localparam int unsigned PREAMBLE_LEN  = 7;
    localparam int unsigned FCS_LEN       = 4;
    localparam logic [31:0] CRC_POLY      = 32'hEDB8_8320;  // 802.3 poly, bit reversed

    ////////////////////
    // sequencer to back end
    ////////////////////

    typedef enum logic [1:0] {
        KIND_PRE,
        KIND_SFD,
        KIND_DATA,
        KIND_FCS
    } beat_kind_e;

    // first && nib_hi marks a whole GMII byte, otherwise nib_hi picks the MII nibble
    typedef struct packed {
        logic       valid;
        beat_kind_e kind;
        logic       first;      // first clock of a byte slot
        logic       nib_hi;
        logic [7:0] data;
    } tx_beat_t;

    typedef struct packed {
        logic [3:0] hi;
        logic [3:0] lo;
    } nibble_pair_t;

    typedef union packed {
        logic [7:0]   whole;    // gmii view
        nibble_pair_t nib;      // mii view
    } tx_byte_u;

    ////////////////////
    // external fifo pair
    ////////////////////

    typedef struct packed {
        logic        ptr_empty;
        logic [15:0] ptr;       // length in [10:0]
        logic [7:0]  data;
    } queue_in_t;

    typedef struct packed {
        logic ptr_rd;
        logic data_rd;
    } queue_rd_t;

endpackage

// File: source/crc32_8023.sv
`timescale 1ns/1ps

module crc32_8023 (
    input  logic                  tx_master_clk,
    input  logic                  rstn_mac,
    input  gmii_tx_pkg::tx_beat_t beat,
    output logic [7:0]            fcs_byte
);
    import gmii_tx_pkg::*;

    logic [31:0] crc_q;

    // one byte through the reflected crc, lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            crc_q <= '1;
        end else if (beat.valid) begin
            case (beat.kind)
                KIND_SFD: begin
                    if (beat.first) begin
                        crc_q <= '1;                            // preset for the new frame
                    end
                end
                KIND_DATA: begin
                    if (beat.first) begin
                        crc_q <= crc_step(crc_q, beat.data);
                    end
                end
                KIND_FCS: begin
                    // nib_hi marks the last clock of a byte slot, gmii or mii
                    if (beat.nib_hi) begin
                        crc_q <= crc_q >> 8;                    // next fcs byte down
                    end
                end
                default: begin
                    crc_q <= crc_q;
                end
            endcase
        end
    end

    // fcs goes out inverted, low byte first
    assign fcs_byte = (beat.kind == KIND_FCS) ? ~crc_q[7:0] : 8'h00;

endmodule

// File: source/tx_frame_seq.sv
`timescale 1ns/1ps

module tx_frame_seq #(
    parameter int unsigned IFG_CYCLES = 12
) (
    input  logic                   tx_master_clk,
    input  logic                   rstn_mac,
    input  logic                   speed,         // 1 = gmii
    input  gmii_tx_pkg::queue_in_t normal_q,
    input  gmii_tx_pkg::queue_in_t tte_q,
    output gmii_tx_pkg::queue_rd_t normal_rd,
    output gmii_tx_pkg::queue_rd_t tte_rd,
    output gmii_tx_pkg::tx_beat_t  beat
);
    import gmii_tx_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PTR,      // descriptor read strobe
        S_DESC,     // descriptor word on the bus
        S_PRE,
        S_SFD,
        S_DATA,
        S_FCS,
        S_GAP
    } seq_state_e;

    seq_state_e       state;
    logic             dir;          // 1 = tte queue owns this frame
    logic             gmii;         // speed latched per frame
    logic [LEN_W-1:0] len;
    logic [LEN_W-1:0] cnt;          // bytes left in phase, or gap clocks left
    logic             nib_ph;       // second mii nibble in progress
    tx_beat_t         beat_q;

    queue_in_t        q_sel;
    logic             byte_last;
    logic             fetch;

    assign q_sel     = dir ? tte_q : normal_q;
    assign byte_last = gmii || nib_ph;

    // pull the next payload byte so it lands on the next slot's first clock
    assign fetch = byte_last &&
                   ((state == S_SFD && len != '0) || (state == S_DATA && cnt != '0));

    assign tte_rd.ptr_rd     = (state == S_PTR) && dir;
    assign normal_rd.ptr_rd  = (state == S_PTR) && !dir;
    assign tte_rd.data_rd    = fetch && dir;
    assign normal_rd.data_rd = fetch && !dir;

    // payload comes straight from the selected fifo, held until the next read
    always_comb begin
        beat = beat_q;
        if (beat_q.kind == KIND_DATA) begin
            beat.data = q_sel.data;
        end
    end

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state  <= S_IDLE;
            dir    <= 1'b0;
            gmii   <= 1'b1;
            len    <= '0;
            cnt    <= '0;
            nib_ph <= 1'b0;
            beat_q <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!tte_q.ptr_empty || !normal_q.ptr_empty) begin
                        dir   <= !tte_q.ptr_empty;      // tte first
                        state <= S_PTR;
                    end
                end
                S_PTR: begin
                    state <= S_DESC;
                end
                S_DESC: begin
                    len           <= q_sel.ptr[LEN_W-1:0];
                    gmii          <= speed;
                    cnt           <= LEN_W'(PREAMBLE_LEN - 1);
                    nib_ph        <= 1'b0;
                    beat_q.valid  <= 1'b1;
                    beat_q.kind   <= KIND_PRE;
                    beat_q.first  <= 1'b1;
                    beat_q.nib_hi <= speed;             // gmii: whole byte at once
                    beat_q.data   <= PREAMBLE_BYTE;
                    state         <= S_PRE;
                end
                S_PRE, S_SFD, S_DATA, S_FCS: begin
                    if (!byte_last) begin
                        // mii, move on to the high nibble
                        nib_ph        <= 1'b1;
                        beat_q.first  <= 1'b0;
                        beat_q.nib_hi <= 1'b1;
                    end else begin
                        nib_ph        <= 1'b0;
                        beat_q.first  <= 1'b1;
                        beat_q.nib_hi <= gmii;
                        case (state)
                            S_PRE: begin
                                if (cnt == '0) begin
                                    beat_q.kind <= KIND_SFD;
                                    beat_q.data <= SFD_BYTE;
                                    state       <= S_SFD;
                                end else begin
                                    cnt <= cnt - 1'b1;
                                end
                            end
                            S_SFD: begin
                                if (len != '0) begin
                                    beat_q.kind <= KIND_DATA;
                                    cnt         <= len - 1'b1;
                                    state       <= S_DATA;
                                end else begin
                                    beat_q.kind <= KIND_FCS;  // empty payload
                                    cnt         <= LEN_W'(FCS_LEN - 1);
                                    state       <= S_FCS;
                                end
                            end
                            S_DATA: begin
                                if (cnt == '0) begin
                                    beat_q.kind <= KIND_FCS;
                                    cnt         <= LEN_W'(FCS_LEN - 1);
                                    state       <= S_FCS;
                                end else begin
                                    cnt <= cnt - 1'b1;
                                end
                            end
                            default: begin
                                if (cnt == '0) begin
                                    beat_q.valid  <= 1'b0;
                                    beat_q.kind   <= KIND_PRE;
                                    beat_q.first  <= 1'b0;
                                    beat_q.nib_hi <= 1'b0;
                                    cnt           <= LEN_W'(IFG_CYCLES - 1);
                                    state         <= S_GAP;
                                end else begin
                                    cnt <= cnt - 1'b1;
                                end
                            end
                        endcase
                    end
                end
                S_GAP: begin
                    if (cnt == '0) begin
                        state <= S_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/tx_gmii_out.sv
`timescale 1ns/1ps

module tx_gmii_out (
    input  logic                  tx_master_clk,
    input  logic                  rstn_mac,
    input  gmii_tx_pkg::tx_beat_t beat,
    input  logic [7:0]            fcs_byte,
    output logic                  gtx_dv,
    output logic [7:0]            gtx_d
);
    import gmii_tx_pkg::*;

    tx_byte_u out_byte;

    always_comb begin
        out_byte.whole = (beat.kind == KIND_FCS) ? fcs_byte : beat.data;
    end

    ////////////////////
    // line register
    ////////////////////

    // first with nib_hi is a gmii byte, otherwise mii nibble by nib_hi
    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            gtx_dv <= 1'b0;
            gtx_d  <= 8'h00;
        end else begin
            gtx_dv <= beat.valid;
            if (!beat.valid) begin
                gtx_d <= 8'h00;
            end else if (beat.first && beat.nib_hi) begin
                gtx_d <= out_byte.whole;
            end else if (beat.nib_hi) begin
                gtx_d <= {4'h0, out_byte.nib.hi};
            end else begin
                gtx_d <= {4'h0, out_byte.nib.lo};    // low nibble leads
            end
        end
    end

endmodule

// File: source/gmii_tx_mac.sv
`timescale 1ns/1ps

module gmii_tx_mac #(
    parameter int unsigned IFG_CYCLES = 12      // gap in clocks after the last fcs byte
) (
    input  logic                   tx_master_clk,
    input  logic                   rstn_mac,
    input  logic                   speed,
    input  gmii_tx_pkg::queue_in_t normal_q,
    input  gmii_tx_pkg::queue_in_t tte_q,
    output gmii_tx_pkg::queue_rd_t normal_rd,
    output gmii_tx_pkg::queue_rd_t tte_rd,
    output logic                   gtx_dv,
    output logic [7:0]             gtx_d
);
    import gmii_tx_pkg::*;

    tx_beat_t   beat;
    logic [7:0] fcs_byte;

    tx_frame_seq #(
        .IFG_CYCLES (IFG_CYCLES)
    ) u_seq (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .speed         (speed),
        .normal_q      (normal_q),
        .tte_q         (tte_q),
        .normal_rd     (normal_rd),
        .tte_rd        (tte_rd),
        .beat          (beat)
    );

    // fcs runs beside the sequencer on the same beats
    crc32_8023 u_crc (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .beat          (beat),
        .fcs_byte      (fcs_byte)
    );

    tx_gmii_out u_out (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .beat          (beat),
        .fcs_byte      (fcs_byte),
        .gtx_dv        (gtx_dv),
        .gtx_d         (gtx_d)
    );

endmodule

// File: test/tb_gmii_tx_mac.sv
`timescale 1ns/1ps

module tb_gmii_tx_mac;
    import gmii_tx_pkg::*;

    typedef logic [7:0] byte_q_t[$];

    localparam int IFG_CYCLES = 12;

    logic       tx_master_clk = 1'b0;
    logic       rstn_mac;
    logic       speed;
    queue_in_t  normal_q;
    queue_in_t  tte_q;
    queue_rd_t  normal_rd;
    queue_rd_t  tte_rd;
    logic       gtx_dv;
    logic [7:0] gtx_d;

    int         n_len_q[$];         // descriptor lengths per fifo model
    byte_q_t    n_pay_q;
    int         t_len_q[$];
    byte_q_t    t_pay_q;
    queue_rd_t  n_pend = '0;        // strobes seen at the last rising edge
    queue_rd_t  t_pend = '0;

    string      exp_name[$];        // expected frames, in line order
    logic       exp_mii[$];
    int         exp_len[$];
    int         exp_base[$];
    byte_q_t    exp_bytes;
    byte_q_t    raw_q;              // line words of the frame in progress

    logic       in_frame = 1'b0;
    int         frames_seen = 0;
    int         low_cnt = 0;
    int         reset_errs = 0;
    int         frame_errs = 0;
    int         frame_fails = 0;
    int         ifg_errs = 0;
    int         cycle_cnt = 0;
    int         cycle_limit = 100;

    gmii_tx_mac #(.IFG_CYCLES(IFG_CYCLES)) DUT (.*);

    always #10 tx_master_clk = ~tx_master_clk;

    // preamble, sfd, payload, then crc-32 low byte first
    function automatic byte_q_t ref_stream(input byte_q_t payload);
        byte_q_t     s;
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < 7; i++) begin
            s.push_back(8'h55);
        end
        s.push_back(8'hD5);
        foreach (payload[i]) begin
            s.push_back(payload[i]);
            crc = crc ^ {24'h0, payload[i]};
            for (int b = 0; b < 8; b++) begin
                crc = (crc >> 1) ^ (32'hEDB8_8320 & {32{crc[0]}});
            end
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) begin
            s.push_back(crc[8*k +: 8]);
        end
        return s;
    endfunction

    task automatic add_frame(input logic to_tte, input string name, input logic mii);
        byte_q_t    payload;
        byte_q_t    stream;
        logic [7:0] b;
        int         len;
        len = $urandom_range(40, 1);
        for (int i = 0; i < len; i++) begin
            b = 8'($urandom);
            payload.push_back(b);
            if (to_tte) t_pay_q.push_back(b);
            else n_pay_q.push_back(b);
        end
        if (to_tte) t_len_q.push_back(len);
        else n_len_q.push_back(len);
        stream = ref_stream(payload);
        exp_name.push_back(name);
        exp_mii.push_back(mii);
        exp_len.push_back(len);
        exp_base.push_back(exp_bytes.size());
        foreach (stream[i]) begin
            exp_bytes.push_back(stream[i]);
        end
        cycle_limit += 2 * (2 * (12 + len) + 12 + 3);
    endtask

    task automatic check_reset_state();
        logic [3:0] strobes;
        strobes = {normal_rd.ptr_rd, normal_rd.data_rd, tte_rd.ptr_rd, tte_rd.data_rd};
        assert (!gtx_dv && gtx_d == 8'h00 && strobes == 4'h0) else begin
            $display("Error reset: expected dv 0 d 00 strobes 0000, actual dv %b d %h strobes %b",
                     gtx_dv, gtx_d, strobes);
            reset_errs++;
        end
    endtask

    task automatic check_frame();
        int         idx;
        int         nbytes;
        int         cycles;
        int         errs_before;
        logic [7:0] got;
        logic [7:0] want;
        string      name;
        idx         = frames_seen;
        errs_before = frame_errs;
        name        = "extra_frame";
        assert (idx < exp_name.size()) else begin
            $display("a frame appeared on the line after all expected frames");
            frame_errs++;
        end
        if (idx < exp_name.size()) begin
            name   = exp_name[idx];
            nbytes = exp_len[idx] + 12;
            cycles = exp_mii[idx] ? 2 * nbytes : nbytes;
            assert (raw_q.size() == cycles) else begin
                $display("Error %s: frame cycles expected %0d, actual %0d",
                         name, cycles, raw_q.size());
                frame_errs++;
            end
            for (int i = 0; i < nbytes; i++) begin
                want = exp_bytes[exp_base[idx] + i];
                got  = raw_q[i];
                if (exp_mii[idx]) begin
                    got = {raw_q[2*i+1][3:0], raw_q[2*i][3:0]};     // low nibble came first
                    assert ({raw_q[2*i+1][7:4], raw_q[2*i][7:4]} == 8'h00) else begin
                        $display("Error %s: byte %0d upper bits expected 00, actual %h",
                                 name, i, {raw_q[2*i+1][7:4], raw_q[2*i][7:4]});
                        frame_errs++;
                    end
                end
                assert (got == want) else begin
                    $display("Error %s: byte %0d expected %h, actual %h", name, i, want, got);
                    frame_errs++;
                end
            end
        end
        if (frame_errs != errs_before) frame_fails++;
        $display("test %s: %s", name, (frame_errs == errs_before) ? "pass" : "fail");
    endtask

    task automatic wait_frames();
        while (frames_seen < exp_name.size()) @(negedge tx_master_clk);
    endtask

    ////////////////////
    // fifo models
    ////////////////////

    always @(posedge tx_master_clk) begin
        n_pend <= normal_rd;
        t_pend <= tte_rd;
    end

    // a read seen at the rising edge brings the next word at the falling edge
    initial begin
        int n_pi;
        int n_di;
        int t_pi;
        int t_di;
        n_pi     = 0;
        n_di     = 0;
        t_pi     = 0;
        t_di     = 0;
        normal_q = '{ptr_empty: 1'b1, ptr: 16'h0000, data: 8'h00};
        tte_q    = '{ptr_empty: 1'b1, ptr: 16'h0000, data: 8'h00};
        forever begin
            @(negedge tx_master_clk);
            if (n_pend.ptr_rd) begin
                normal_q.ptr = {5'($urandom), 11'(n_len_q[n_pi])};  // top bits are junk
                n_pi++;
            end
            if (n_pend.data_rd) begin
                normal_q.data = n_pay_q[n_di];
                n_di++;
            end
            if (t_pend.ptr_rd) begin
                tte_q.ptr = {5'($urandom), 11'(t_len_q[t_pi])};
                t_pi++;
            end
            if (t_pend.data_rd) begin
                tte_q.data = t_pay_q[t_di];
                t_di++;
            end
            normal_q.ptr_empty = (n_pi >= n_len_q.size());
            tte_q.ptr_empty    = (t_pi >= t_len_q.size());
        end
    end

    ////////////////////
    // collector
    ////////////////////

    always @(negedge tx_master_clk) begin
        if (rstn_mac && gtx_dv) begin
            if (!in_frame && frames_seen > 0) begin
                assert (low_cnt >= IFG_CYCLES + 2) else begin
                    $display("Error ifg: low cycles expected at least %0d, actual %0d",
                             IFG_CYCLES + 2, low_cnt);
                    ifg_errs++;
                end
            end
            in_frame = 1'b1;
            raw_q.push_back(gtx_d);
        end else if (in_frame) begin
            in_frame = 1'b0;
            check_frame();
            raw_q.delete();
            frames_seen++;
            low_cnt = 1;
        end else begin
            low_cnt++;
        end
    end

    always @(posedge tx_master_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("run stopped at cycle %0d, the frames did not finish in time", cycle_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        int          fails;
        int          errs;
        void'($urandom(31));
        rstn_mac = 1'b0;
        speed    = 1'b1;
        // both queues hold frames before reset lets go
        add_frame(1'b1, "tte_first", 1'b0);
        add_frame(1'b0, "normal_after_tte_a", 1'b0);
        add_frame(1'b0, "normal_after_tte_b", 1'b0);
        repeat (10) begin
            @(negedge tx_master_clk);
            check_reset_state();
        end
        rstn_mac = 1'b1;
        #1;
        check_reset_state();
        $display("test reset: %s", (reset_errs == 0) ? "pass" : "fail");
        wait_frames();
        add_frame(1'b0, "gmii_frame", 1'b0);
        wait_frames();
        speed = 1'b0;                   // mii from here on
        add_frame(1'b0, "mii_frame_a", 1'b1);
        add_frame(1'b0, "mii_frame_b", 1'b1);
        wait_frames();
        $display("test ifg: %s", (ifg_errs == 0) ? "pass" : "fail");
        errs  = reset_errs + frame_errs + ifg_errs;
        fails = frame_fails + int'(reset_errs != 0) + int'(ifg_errs != 0);
        $display("tests %0d, failed %0d, errors %0d", frames_seen + 2, fails, errs);
        if (errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tb.f
source/gmii_tx_pkg.sv
source/crc32_8023.sv
source/tx_frame_seq.sv
source/tx_gmii_out.sv
source/gmii_tx_mac.sv
test/tb_gmii_tx_mac.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_gmii_tx_mac \
        -o tb_gmii_tx_mac > build.log 2>&1; then
    cat build.log
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/tb_gmii_tx_mac > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -qx "All checks passed" sim.log; then
    exit 0
fi
exit 1
